// ==== src.f ====
+incdir+bench
hdl/lsu_pkg.sv
hdl/lsu_store_fmt.sv
hdl/lsu_load_fmt.sv
hdl/lsu_dtlb.sv
hdl/lsu_ctrl.sv
hdl/lsu_top.sv
bench/tb_lsu_top.sv

// ==== bench/tb_lsu_tasks.svh ====
// Directed tests for the load/store unit
// Reference models, access drivers and immediate-assertion checks

function automatic logic [3:0] lane_mask(input int size, input int off);
   int k;
   lane_mask = 4'b0000;
   for (k = off; k < off + size; k++)
      lane_mask[3 - k] = 1'b1;                            // Lane 0 sits at bit 3
endfunction

function automatic logic [31:0] place_store(input logic [31:0] w, input logic [31:0] d,
                                           input int size, input int off);
   int k;
   for (k = 0; k < size; k++)
      w[31 - 8*(off + k) -: 8] = d[8*(size - 1 - k) +: 8];   // MS byte of operand goes first
   place_store = w;
endfunction

function automatic logic [31:0] load_ref(input logic [31:0] w, input int size, input int off,
                                        input logic sext);
   logic [31:0] v;
   int k;
   v = 32'h0;
   for (k = off; k < off + size; k++)
      v = (v << 8) | w[31 - 8*k -: 8];
   if (sext && size < 4 && v[8*size - 1])
      v = v | (32'hffff_ffff << (8*size));
   load_ref = v;
endfunction

function automatic logic [31:0] page_adr(input logic [31:0] pn, input logic [31:0] off);
   page_adr = (pn << lsu_pkg::PAGE_BITS) | off;
endfunction

task automatic require(input logic cond, input string why);
   assert (cond) else stop_with_failure(why);
endtask

task automatic compare_word(input string sig, input logic [31:0] got, input logic [31:0] exp);
   assert (got === exp) else
      stop_with_failure($sformatf("ERROR %s = 0x%h, expected 0x%h", sig, got, exp));
endtask

// Present one access, return at the edge where it ended or trapped
task automatic drive_access(input logic st, input logic [5:0] opc, input logic [31:0] adr,
                            input logic [31:0] rfb);
   logic finished;
   @(negedge clk);
   ctrl_op_load_i  = !st;
   ctrl_op_store_i = st;
   ctrl_opc_i      = opc;
   ctrl_adr_i      = adr;
   ctrl_rfb_i      = rfb;
   saw_req         = 1'b0;
   finished        = 1'b0;
   while (!finished) begin
      @(posedge clk);
      if (dbus_req_o) begin
         saw_req   = 1'b1;
         seen_bsel = dbus_bsel_o;
         seen_adr  = dbus_adr_o;
      end
      finished = lsu_valid_o || lsu_except_dbus_o || lsu_except_align_o ||
                 lsu_except_dtlb_miss_o || lsu_except_dpagefault_o;
   end
endtask

task automatic retire();
   @(negedge clk);
   padv_execute_i  = 1'b1;
   ctrl_op_load_i  = 1'b0;
   ctrl_op_store_i = 1'b0;
   @(negedge clk);
   padv_execute_i  = 1'b0;
endtask

task automatic spr_access(input logic we, input logic [15:0] addr, input logic [31:0] wdat,
                          output logic [31:0] rdat);
   @(negedge clk);
   spr_bus_stb_i  = 1'b1;
   spr_bus_we_i   = we;
   spr_bus_addr_i = addr;
   spr_bus_dat_i  = wdat;
   @(posedge clk);
   require(!spr_bus_ack_o, "SPR ack came in the strobe cycle");
   @(negedge clk);
   spr_bus_stb_i  = 1'b0;
   @(posedge clk);
   require(spr_bus_ack_o, "SPR ack missing one cycle after the strobe");
   rdat = spr_bus_dat_o;
endtask

// Perm order is URE, UWE, SRE, SWE from bit 0
task automatic write_entry(input logic [31:0] vpn, input logic valid, input logic [31:0] ppn,
                           input logic [3:0] perm);
   logic [15:0] set;
   logic [31:0] mw;
   logic [31:0] xw;
   logic [31:0] rd;
   set = 16'(vpn & ((1 << SET_W) - 1));
   mw  = page_adr(vpn, 32'(valid));
   xw  = page_adr(ppn, 32'(perm) << lsu_pkg::XL_URE);
   spr_access(1'b1, lsu_pkg::SPR_DTLB_MATCH + set, mw, rd);
   spr_access(1'b1, lsu_pkg::SPR_DTLB_XLATE + set, xw, rd);
   spr_access(1'b0, lsu_pkg::SPR_DTLB_MATCH + set, 32'h0, rd);
   compare_word("spr_bus_dat_o", rd, mw);
   spr_access(1'b0, lsu_pkg::SPR_DTLB_XLATE + set, 32'h0, rd);
   compare_word("spr_bus_dat_o", rd, xw);
endtask

task automatic store_load_sweep();
   logic [31:0] shadow;                                   // Expected memory word
   logic [31:0] data;
   int j;
   int off;
   int i;
   int lo;
   int size;
   int lsize;
   for (j = 0; j < 3; j++) begin                          // sw, sb, sh
      size = (j == 0) ? 4 : (j == 1) ? 1 : 2;
      for (off = 0; off < 4; off += size) begin
         data = 32'h9c3e_f185 ^ (off * 32'h1111_1111) ^ (j * 32'h2468_ace0);
         drive_access(1'b1, 6'(lsu_pkg::OPC_SW + j), BASE + off, data);
         require(saw_req, "Aligned store made no bus request");
         compare_word("dbus_bsel_o", seen_bsel, lane_mask(size, off));
         shadow = place_store(shadow, data, size, off);
         retire();
         for (i = 0; i < 6; i++) begin                    // lwz lws lbz lbs lhz lhs
            lsize = (i < 2) ? 4 : (i < 4) ? 1 : 2;
            for (lo = 0; lo < 4; lo += lsize) begin
               drive_access(1'b0, 6'(lsu_pkg::OPC_LWZ + i), BASE + lo, 32'h0);
               require(saw_req, "Aligned load made no bus request");
               compare_word("dbus_bsel_o", seen_bsel, lane_mask(lsize, lo));
               compare_word("lsu_result_o", lsu_result_o, load_ref(shadow, lsize, lo, i % 2 == 1));
               retire();
            end
         end
      end
   end
endtask

task automatic expect_align(input logic st, input logic [5:0] opc, input logic [31:0] adr);
   drive_access(st, opc, adr, 32'h0);
   require(lsu_except_align_o, "Misaligned access raised no alignment exception");
   @(posedge clk);
   require(!saw_req && !dbus_req_o, "Misaligned access reached the bus");
   retire();
endtask

task automatic misaligned_accesses();
   int off;
   for (off = 1; off < 4; off++) begin
      expect_align(1'b0, lsu_pkg::OPC_LWZ, BASE + off);
      expect_align(1'b1, lsu_pkg::OPC_SW, BASE + off);
      if (off != 2) begin
         expect_align(1'b0, lsu_pkg::OPC_LHS, BASE + off);
         expect_align(1'b1, lsu_pkg::OPC_SH, BASE + off);
      end
   end
endtask

task automatic bus_error();
   err_mode = 1'b1;
   drive_access(1'b0, lsu_pkg::OPC_LWZ, BASE, 32'h0);
   require(lsu_except_dbus_o, "Bus error gave no bus exception");
   repeat (3) begin
      @(posedge clk);
      require(lsu_except_dbus_o, "Bus exception dropped before the advance pulse");
      require(!dbus_req_o, "Request retried after a bus error");
   end
   err_mode = 1'b0;
   retire();
   @(posedge clk);
   require(!lsu_except_dbus_o, "Bus exception still set after the advance pulse");
endtask

task automatic result_hold();
   logic [31:0] held;
   drive_access(1'b0, lsu_pkg::OPC_LHS, BASE + 2, 32'h0);
   held     = lsu_result_o;
   scramble = 1'b1;                                       // Bus data keeps changing now
   repeat (4) begin
      @(posedge clk);
      require(lsu_valid_o, "lsu_valid_o dropped before the advance pulse");
      compare_word("lsu_result_o", lsu_result_o, held);
   end
   scramble = 1'b0;
   retire();
   @(posedge clk);
   require(!lsu_valid_o, "lsu_valid_o still high after the advance pulse");
endtask

task automatic expect_tlb_fault(input logic st, input logic [31:0] adr, input logic miss);
   drive_access(st, st ? lsu_pkg::OPC_SW : lsu_pkg::OPC_LWZ, adr, 32'h0);
   repeat (3) begin
      compare_word("lsu_except_dtlb_miss_o", lsu_except_dtlb_miss_o, miss);
      compare_word("lsu_except_dpagefault_o", lsu_except_dpagefault_o, !miss);
      require(!saw_req && !dbus_req_o, "TLB exception case reached the bus");
      @(negedge clk);
      dmmu_enable_i = 1'b0;                               // Lookup quiet, only latched flags hold
      @(posedge clk);
   end
   retire();
   dmmu_enable_i = 1'b1;
   @(posedge clk);
   require(!lsu_except_dtlb_miss_o && !lsu_except_dpagefault_o,
           "TLB exception still set after the advance pulse");
endtask

task automatic tlb_checks();
   logic [31:0] vpn;
   vpn               = 32'h2_3456;
   dmmu_enable_i     = 1'b1;
   supervisor_mode_i = 1'b1;
   write_entry(vpn, 1'b1, 32'h7, 4'b1111);
   drive_access(1'b1, lsu_pkg::OPC_SW, page_adr(vpn, 32'h108), 32'h5566_7788);
   compare_word("dbus_adr_o", seen_adr, page_adr(32'h7, 32'h108));
   retire();
   drive_access(1'b0, lsu_pkg::OPC_LWZ, page_adr(vpn, 32'h108), 32'h0);
   compare_word("dbus_adr_o", seen_adr, page_adr(32'h7, 32'h108));
   compare_word("lsu_result_o", lsu_result_o, 32'h5566_7788);
   retire();
   expect_tlb_fault(1'b0, page_adr(vpn + (1 << SET_W), 32'h108), 1'b1);   // Same set, other VPN
   write_entry(32'h11, 1'b0, 32'h2, 4'b1111);
   expect_tlb_fault(1'b0, page_adr(32'h11, 32'h10), 1'b1);                // Entry invalid
   write_entry(32'h12, 1'b1, 32'h3, 4'b1101);                             // No user write
   supervisor_mode_i = 1'b0;
   expect_tlb_fault(1'b1, page_adr(32'h12, 32'h10), 1'b0);
   supervisor_mode_i = 1'b1;
endtask

// ==== bench/tb_lsu_top.sv ====
// Load/store unit testbench
// Clock, reset, bus memory model, watchdog and test sequence
`timescale 1ns/100ps
`default_nettype none

module tb_lsu_top;

   localparam int SET_W     = 6;                          // DTLB set index width
   localparam int MAX_DELAY = 3;                          // Longest memory ack delay
   localparam int N_ACCESS  = 130;                        // Bus accesses over all tests
   localparam int TIMEOUT   = (N_ACCESS * (MAX_DELAY + 8) + 300) * 20;
   localparam logic [31:0] BASE = 32'h0000_0100;          // Word used by the sweep

   logic        clk;
   logic        rst;
   logic        padv_execute_i;
   logic        ctrl_op_load_i;
   logic        ctrl_op_store_i;
   logic [5:0]  ctrl_opc_i;
   logic [31:0] ctrl_adr_i;
   logic [31:0] ctrl_rfb_i;
   logic        pipeline_flush_i;
   logic        dmmu_enable_i;
   logic        supervisor_mode_i;
   logic [15:0] spr_bus_addr_i;
   logic        spr_bus_we_i;
   logic        spr_bus_stb_i;
   logic [31:0] spr_bus_dat_i;
   logic        dbus_ack_i = 1'b0;                        // Memory model drives these
   logic        dbus_err_i = 1'b0;
   logic [31:0] dbus_dat_i = 32'h0;
   wire  [31:0] lsu_result_o;
   wire         lsu_valid_o;
   wire         lsu_except_dbus_o;
   wire         lsu_except_align_o;
   wire         lsu_except_dtlb_miss_o;
   wire         lsu_except_dpagefault_o;
   wire  [31:0] spr_bus_dat_o;
   wire         spr_bus_ack_o;
   wire  [31:0] dbus_adr_o;
   wire         dbus_req_o;
   wire  [31:0] dbus_dat_o;
   wire  [3:0]  dbus_bsel_o;
   wire         dbus_we_o;

   logic [31:0] mem [256];                                // Bus memory, word addressed
   logic [15:0] lfsr = 16'd65;
   logic        req_q = 1'b0;                             // Pending request seen at rising edge
   logic        busy = 1'b0;
   logic [1:0]  delay = 2'd0;
   logic        err_mode = 1'b0;                          // Answer with err instead of ack
   logic        scramble = 1'b0;                          // Toggle read data while idle
   logic        saw_req;
   logic [3:0]  seen_bsel;
   logic [31:0] seen_adr;
   int          fill_idx;

   lsu_top #(.DW(32), .DTLB_SET_W(SET_W)) uut (.*);

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11
   endfunction

   function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] dat,
                                              input logic [3:0] sel);
      int k;
      merge_lanes = old;
      for (k = 0; k < 4; k++)
         if (sel[3 - k])
            merge_lanes[31 - 8*k -: 8] = dat[31 - 8*k -: 8];
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1, "Simulation stopped at first failure");
   endtask

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk)
      req_q = dbus_req_o && !dbus_ack_i && !dbus_err_i;   // Ignore the request in its ack cycle

   // Answered at the falling edge after a random delay
   always @(negedge clk) begin
      dbus_ack_i = 1'b0;
      dbus_err_i = 1'b0;
      if (scramble)
         dbus_dat_i = ~dbus_dat_i;
      if (!req_q) begin
         busy = 1'b0;
      end else begin
         if (!busy) begin
            busy     = 1'b1;
            lfsr     = lfsr_step(lfsr);
            delay[0] = lfsr[0];
            lfsr     = lfsr_step(lfsr);
            delay[1] = lfsr[0];
         end
         if (delay != 2'd0) begin
            delay = delay - 2'd1;
         end else begin
            busy = 1'b0;
            if (err_mode) begin
               dbus_err_i = 1'b1;
            end else begin
               dbus_ack_i = 1'b1;
               if (dbus_we_o)
                  mem[dbus_adr_o[9:2]] = merge_lanes(mem[dbus_adr_o[9:2]], dbus_dat_o, dbus_bsel_o);
               else
                  dbus_dat_i = mem[dbus_adr_o[9:2]];
            end
         end
      end
   end

   initial begin
      #(TIMEOUT);
      stop_with_failure("Watchdog expired before the tests finished");
   end

   initial begin
      rst               = 1'b1;
      padv_execute_i    = 1'b0;
      ctrl_op_load_i    = 1'b0;
      ctrl_op_store_i   = 1'b0;
      ctrl_opc_i        = 6'h00;
      ctrl_adr_i        = 32'h0;
      ctrl_rfb_i        = 32'h0;
      pipeline_flush_i  = 1'b0;
      dmmu_enable_i     = 1'b0;
      supervisor_mode_i = 1'b1;
      spr_bus_addr_i    = 16'h0;
      spr_bus_we_i      = 1'b0;
      spr_bus_stb_i     = 1'b0;
      spr_bus_dat_i     = 32'h0;
      for (fill_idx = 0; fill_idx < 256; fill_idx++)   // Every byte tied to the word address
         mem[fill_idx] = {fill_idx[7:0], ~fill_idx[7:0], fill_idx[7:0] ^ 8'h5a, 8'hc3};
      repeat (2) @(negedge clk);
      rst = 1'b0;
      require(!dbus_req_o && !lsu_valid_o && !spr_bus_ack_o, "Outputs not idle after reset");
      require(!(lsu_except_dbus_o || lsu_except_align_o || lsu_except_dtlb_miss_o ||
                lsu_except_dpagefault_o), "Exception raised right after reset");
      store_load_sweep();
      misaligned_accesses();
      bus_error();
      result_hold();
      tlb_checks();                                       // Leaves the DMMU enabled
      $display("=== PASS ===");
      $finish;
   end

   `include "tb_lsu_tasks.svh"

endmodule

`default_nettype wire

// ==== hdl/lsu_top.sv ====
// Load/store unit top level
// DTLB, store and load formatters, request control
`timescale 1ns/100ps
`default_nettype none

module lsu_top #(
   parameter int DW         = 32,
   parameter int DTLB_SET_W = 6
) (
   input  wire                        clk,
   input  wire                        rst,
   input  wire                        padv_execute_i,
   input  wire                        ctrl_op_load_i,
   input  wire                        ctrl_op_store_i,
   input  wire [lsu_pkg::OPC_W-1:0]   ctrl_opc_i,
   input  wire [DW-1:0]               ctrl_adr_i,         // Virtual effective address
   input  wire [DW-1:0]               ctrl_rfb_i,
   input  wire                        pipeline_flush_i,
   input  wire                        dmmu_enable_i,
   input  wire                        supervisor_mode_i,
   output logic [DW-1:0]              lsu_result_o,
   output logic                       lsu_valid_o,
   output logic                       lsu_except_dbus_o,
   output logic                       lsu_except_align_o,
   output logic                       lsu_except_dtlb_miss_o,
   output logic                       lsu_except_dpagefault_o,
   input  wire [15:0]                 spr_bus_addr_i,
   input  wire                        spr_bus_we_i,
   input  wire                        spr_bus_stb_i,
   input  wire [DW-1:0]               spr_bus_dat_i,
   output logic [DW-1:0]              spr_bus_dat_o,
   output logic                       spr_bus_ack_o,
   output logic [DW-1:0]              dbus_adr_o,         // Physical address
   output logic                       dbus_req_o,
   output logic [DW-1:0]              dbus_dat_o,
   output logic [3:0]                 dbus_bsel_o,
   output logic                       dbus_we_o,
   input  wire                        dbus_ack_i,
   input  wire                        dbus_err_i,
   input  wire [DW-1:0]               dbus_dat_i
);

   logic          tlb_miss;
   logic          pagefault;
   logic [DW-1:0] ld_dat;

   assign dbus_we_o = ctrl_op_store_i;

   lsu_dtlb #(.DW(DW), .DTLB_SET_W(DTLB_SET_W)) u_dtlb (
      .clk(clk), .rst(rst),
      .enable_i(dmmu_enable_i), .supervisor_i(supervisor_mode_i),
      .load_i(ctrl_op_load_i), .store_i(ctrl_op_store_i),
      .vadr_i(ctrl_adr_i), .padr_o(dbus_adr_o),
      .tlb_miss_o(tlb_miss), .pagefault_o(pagefault),
      .spr_addr_i(spr_bus_addr_i), .spr_we_i(spr_bus_we_i), .spr_stb_i(spr_bus_stb_i),
      .spr_dat_i(spr_bus_dat_i), .spr_dat_o(spr_bus_dat_o), .spr_ack_o(spr_bus_ack_o)
   );

   lsu_store_fmt #(.DW(DW)) u_store_fmt (
      .opc_i(ctrl_opc_i), .adr_lo_i(dbus_adr_o[1:0]),     // Page offset, same before and after xlate
      .load_i(ctrl_op_load_i), .store_i(ctrl_op_store_i),
      .rfb_i(ctrl_rfb_i), .bsel_o(dbus_bsel_o), .st_dat_o(dbus_dat_o),
      .align_err_o(lsu_except_align_o)
   );

   lsu_load_fmt #(.DW(DW)) u_load_fmt (
      .opc_i(ctrl_opc_i), .adr_lo_i(dbus_adr_o[1:0]),
      .bus_dat_i(dbus_dat_i), .ld_dat_o(ld_dat)
   );

   lsu_ctrl #(.DW(DW)) u_ctrl (
      .clk(clk), .rst(rst),
      .padv_execute_i(padv_execute_i), .pipeline_flush_i(pipeline_flush_i),
      .load_i(ctrl_op_load_i), .store_i(ctrl_op_store_i),
      .align_err_i(lsu_except_align_o), .tlb_miss_i(tlb_miss), .pagefault_i(pagefault),
      .ack_i(dbus_ack_i), .err_i(dbus_err_i), .ld_dat_i(ld_dat),
      .dbus_req_o(dbus_req_o), .lsu_valid_o(lsu_valid_o), .lsu_result_o(lsu_result_o),
      .except_dbus_o(lsu_except_dbus_o), .except_dtlb_miss_o(lsu_except_dtlb_miss_o),
      .except_dpagefault_o(lsu_except_dpagefault_o)
   );

endmodule

`default_nettype wire

// ==== hdl/lsu_ctrl.sv ====
// Data bus request gating, sticky exception flags
// Access-done tracking and load result register
`timescale 1ns/100ps
`default_nettype none

module lsu_ctrl #(
   parameter int DW = 32
) (
   input  wire            clk,
   input  wire            rst,
   input  wire            padv_execute_i,                 // Clears per-instruction state
   input  wire            pipeline_flush_i,
   input  wire            load_i,
   input  wire            store_i,
   input  wire            align_err_i,
   input  wire            tlb_miss_i,
   input  wire            pagefault_i,
   input  wire            ack_i,
   input  wire            err_i,
   input  wire [DW-1:0]   ld_dat_i,                       // Formatted load data
   output logic           dbus_req_o,
   output logic           lsu_valid_o,
   output logic [DW-1:0]  lsu_result_o,
   output logic           except_dbus_o,
   output logic           except_dtlb_miss_o,
   output logic           except_dpagefault_o
);

   logic          access_done;
   logic          dbus_err_r;
   logic          miss_r;
   logic          fault_r;
   logic [DW-1:0] result_r;

   assign dbus_req_o = (load_i || store_i) && !align_err_i &&
                       !(tlb_miss_i || miss_r) && !(pagefault_i || fault_r) &&
                       !access_done && !pipeline_flush_i;

   assign lsu_valid_o         = ack_i || access_done;
   assign lsu_result_o        = access_done ? result_r : ld_dat_i;   // Bypass in ack cycle
   assign except_dbus_o       = err_i || dbus_err_r;
   assign except_dtlb_miss_o  = tlb_miss_i || miss_r;
   assign except_dpagefault_o = pagefault_i || fault_r;

   always_ff @(posedge clk) begin
      if (rst) begin
         access_done <= 1'b0;
         dbus_err_r  <= 1'b0;
         miss_r      <= 1'b0;
         fault_r     <= 1'b0;
      end else begin
         if (padv_execute_i)
            access_done <= 1'b0;
         else if (ack_i || err_i)
            access_done <= 1'b1;                          // Error also ends access, no retry

         if (padv_execute_i || pipeline_flush_i)
            dbus_err_r <= 1'b0;
         else if (err_i)
            dbus_err_r <= 1'b1;

         if (padv_execute_i)
            miss_r <= 1'b0;
         else if (tlb_miss_i)
            miss_r <= 1'b1;

         if (padv_execute_i)
            fault_r <= 1'b0;
         else if (pagefault_i)
            fault_r <= 1'b1;
      end
   end

   // Hold load data until writeback
   always_ff @(posedge clk) begin
      if (ack_i && load_i)
         result_r <= ld_dat_i;
   end

endmodule

`default_nettype wire

// ==== hdl/lsu_dtlb.sv ====
// Direct-mapped data TLB with SPR-programmed entries
// Combinational lookup, miss and permission checks
`timescale 1ns/100ps
`default_nettype none

module lsu_dtlb #(
   parameter int DW         = 32,
   parameter int DTLB_SET_W = 6
) (
   input  wire            clk,
   input  wire            rst,
   input  wire            enable_i,                       // DMMU on
   input  wire            supervisor_i,
   input  wire            load_i,
   input  wire            store_i,
   input  wire [DW-1:0]   vadr_i,
   output logic [DW-1:0]  padr_o,
   output logic           tlb_miss_o,
   output logic           pagefault_o,
   input  wire [15:0]     spr_addr_i,
   input  wire            spr_we_i,
   input  wire            spr_stb_i,
   input  wire [DW-1:0]   spr_dat_i,
   output logic [DW-1:0]  spr_dat_o,
   output logic           spr_ack_o
);

   localparam int NSETS = 1 << DTLB_SET_W;
   localparam int PB    = lsu_pkg::PAGE_BITS;

   logic [DW-1:1]         match_mem [NSETS];              // VPN and spare bits, valid kept apart
   logic [DW-1:0]         xlate_mem [NSETS];              // PPN and permissions
   logic [NSETS-1:0]      valid_r;

   logic [DTLB_SET_W-1:0] idx;
   logic [DTLB_SET_W-1:0] spr_idx;
   logic [DW-1:0]         xl;
   logic                  access;
   logic                  hit;
   logic                  perm;
   logic                  spr_match_sel;
   logic                  spr_xlate_sel;

   // Lookup
   assign idx    = vadr_i[PB +: DTLB_SET_W];              // Low VPN bits pick the set
   assign xl     = xlate_mem[idx];
   assign access = load_i || store_i;
   assign hit    = valid_r[idx] && (match_mem[idx][DW-1:PB] == vadr_i[DW-1:PB]);

   always_comb begin
      if (supervisor_i)
         perm = store_i ? xl[lsu_pkg::XL_SWE] : xl[lsu_pkg::XL_SRE];
      else
         perm = store_i ? xl[lsu_pkg::XL_UWE] : xl[lsu_pkg::XL_URE];
   end

   assign tlb_miss_o  = enable_i && access && !hit;
   assign pagefault_o = enable_i && access && hit && !perm;   // Only meaningful on a hit
   assign padr_o      = enable_i ? {xl[DW-1:PB], vadr_i[PB-1:0]} : vadr_i;

   // SPR window decode
   assign spr_idx       = spr_addr_i[DTLB_SET_W-1:0];
   assign spr_match_sel = spr_stb_i &&
                          ((spr_addr_i >> DTLB_SET_W) == (lsu_pkg::SPR_DTLB_MATCH >> DTLB_SET_W));
   assign spr_xlate_sel = spr_stb_i &&
                          ((spr_addr_i >> DTLB_SET_W) == (lsu_pkg::SPR_DTLB_XLATE >> DTLB_SET_W));

   // Entry storage and read data
   always_ff @(posedge clk) begin
      if (spr_match_sel && spr_we_i)
         match_mem[spr_idx] <= spr_dat_i[DW-1:1];
      if (spr_xlate_sel && spr_we_i)
         xlate_mem[spr_idx] <= spr_dat_i;
      if ((spr_match_sel || spr_xlate_sel) && !spr_we_i)
         spr_dat_o <= spr_match_sel ? {match_mem[spr_idx], valid_r[spr_idx]}
                                    : xlate_mem[spr_idx];
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_r   <= '0;                                 // All sets invalid
         spr_ack_o <= 1'b0;
      end else begin
         spr_ack_o <= spr_match_sel || spr_xlate_sel;     // Ack one cycle after strobe
         if (spr_match_sel && spr_we_i)
            valid_r[spr_idx] <= spr_dat_i[0];
      end
   end

endmodule

`default_nettype wire

// ==== hdl/lsu_load_fmt.sv ====
// Load data lane selection and sign or zero extension
`timescale 1ns/100ps
`default_nettype none

module lsu_load_fmt #(
   parameter int DW = 32
) (
   input  wire lsu_pkg::lsu_opc_u opc_i,
   input  wire [1:0]              adr_lo_i,
   input  wire [DW-1:0]           bus_dat_i,              // Raw word from data bus
   output logic [DW-1:0]          ld_dat_o
);

   logic [DW-1:0] aligned;
   logic          zext;
   logic          sign;                                   // Lane MSB unless zero extending

   // Addressed lane moved up to the MSB end
   assign aligned = bus_dat_i << {adr_lo_i, 3'b000};

   assign zext = opc_i.ld.kind[0];                        // Odd kinds are the Z loads
   assign sign = !zext && aligned[DW-1];

   // Right-justify and extend
   always_comb begin
      case (opc_i)
         lsu_pkg::OPC_LBZ,
         lsu_pkg::OPC_LBS:
            ld_dat_o = {{(DW-8){sign}}, aligned[DW-1 -: 8]};
         lsu_pkg::OPC_LHZ,
         lsu_pkg::OPC_LHS:
            ld_dat_o = {{(DW-16){sign}}, aligned[DW-1 -: 16]};
         default:
            ld_dat_o = aligned;                           // Word loads need no shift
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/lsu_store_fmt.sv ====
// Store data replication, big-endian byte selects
// Alignment check for loads and stores
`timescale 1ns/100ps
`default_nettype none

module lsu_store_fmt #(
   parameter int DW = 32
) (
   input  wire lsu_pkg::lsu_opc_u opc_i,
   input  wire [1:0]              adr_lo_i,               // Physical address bits 1:0
   input  wire                    load_i,
   input  wire                    store_i,
   input  wire [DW-1:0]           rfb_i,                  // Store operand
   output logic [3:0]             bsel_o,
   output logic [DW-1:0]          st_dat_o,
   output logic                   align_err_o
);

   logic is_byte;
   logic is_half;

   // Access size, each path reads its own view of the opcode
   always_comb begin
      is_byte = 1'b0;
      is_half = 1'b0;
      if (store_i) begin
         is_byte = (opc_i.st.size == 2'b10);
         is_half = (opc_i.st.size == 2'b11);
      end else if (load_i) begin
         is_byte = (opc_i.ld.kind == 3'b011) || (opc_i.ld.kind == 3'b100);   // lbz, lbs
         is_half = (opc_i.ld.kind == 3'b101) || (opc_i.ld.kind == 3'b110);   // lhz, lhs
      end
   end

   // Lane 0 is the MSB on a big-endian bus
   always_comb begin
      if (!(load_i || store_i))
         bsel_o = 4'b0000;                                // Idle
      else if (is_byte)
         bsel_o = 4'b1000 >> adr_lo_i;
      else if (is_half)
         bsel_o = adr_lo_i[1] ? 4'b0011 : 4'b1100;
      else
         bsel_o = 4'b1111;                                // Word
   end

   // Replicate narrow data over all lanes
   always_comb begin
      case (opc_i.st.size)
         2'b10:   st_dat_o = {(DW/8){rfb_i[7:0]}};        // sb
         2'b11:   st_dat_o = {(DW/16){rfb_i[15:0]}};      // sh
         default: st_dat_o = rfb_i;                       // sw
      endcase
   end

   assign align_err_o = (load_i || store_i) &&
                        (is_half ? adr_lo_i[0] : (!is_byte && (|adr_lo_i)));

endmodule

`default_nettype wire

// ==== hdl/lsu_pkg.sv ====
// Load/store unit shared definitions
// Opcodes, opcode views, page geometry and DTLB SPR map
`default_nettype none

package lsu_pkg;

   localparam int OPC_W = 6;                              // Major opcode field width

   // Load opcodes
   localparam logic [OPC_W-1:0] OPC_LWZ = 6'h21;
   localparam logic [OPC_W-1:0] OPC_LWS = 6'h22;
   localparam logic [OPC_W-1:0] OPC_LBZ = 6'h23;
   localparam logic [OPC_W-1:0] OPC_LBS = 6'h24;
   localparam logic [OPC_W-1:0] OPC_LHZ = 6'h25;
   localparam logic [OPC_W-1:0] OPC_LHS = 6'h26;

   // Store opcodes
   localparam logic [OPC_W-1:0] OPC_SW  = 6'h35;
   localparam logic [OPC_W-1:0] OPC_SB  = 6'h36;
   localparam logic [OPC_W-1:0] OPC_SH  = 6'h37;

   // Same opcode word, split differently by load and store paths
   typedef union packed {
      struct packed {
         logic [2:0] major;
         logic [2:0] kind;                                // Bit 0 set means zero extend
      } ld;
      struct packed {
         logic [3:0] major;
         logic [1:0] size;                                // 2 byte, 3 halfword, else word
      } st;
   } lsu_opc_u;

   localparam int PAGE_BITS = 13;                         // 8 KiB pages

   // DTLB SPR windows, set index added to base
   localparam logic [15:0] SPR_DTLB_MATCH = 16'h0A00;
   localparam logic [15:0] SPR_DTLB_XLATE = 16'h0A80;

   // Permission bits in translate word
   localparam int XL_URE = 6;                             // User read
   localparam int XL_UWE = 7;                             // User write
   localparam int XL_SRE = 8;                             // Supervisor read
   localparam int XL_SWE = 9;                             // Supervisor write

endpackage

`default_nettype wire
